// File: src.f
dmac_chn_pkg.sv
ahb_reg_slave.sv
chn_cfg_regs.sv
chn_int_regs.sv
chn_ctrl_regs.sv
dmac_chn_regs.sv
dmac_chn_properties.sv
tb_dmac_chn_regs.sv

// File: tb_dmac_chn_regs.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dmac_chn_regs
  import dmac_chn_pkg::*;
;

  localparam logic [1:0] HTRANS_IDLE = 2'b00;
  localparam word_t      ADDR_HI     = 32'h4000_0000;
  localparam int         SFW_TIMEOUT = 4;

  typedef enum {
    row_wr, row_rd, row_wr_nosel, row_rd_nosel, row_wr_idle, row_rd_idle,
    row_evt, row_sreq, row_chk
  } row_kind_e;

  // Event bits 4..0 follow int_vec_t and bit 5 is chnen_clr.
  typedef struct {
    row_kind_e  kind;
    reg_off_t   off;
    word_t      data;
    logic [5:0] evt;
    word_t      exp;
    logic [2:0] flags;
  } row_t;

  logic hclk = 1'b0;
  logic hrst_n;
  logic s_hsel;
  logic [1:0] s_htrans;
  word_t s_haddr;
  logic s_hwrite;
  word_t s_hwdata;
  word_t s_hrdata;
  logic err_vld;
  logic htfr_vld;
  logic tfr_vld;
  logic trgetcmp_vld;
  logic pd_vld;
  logic chnen_clr;
  word_t sarn;
  word_t darn;
  logic dgrpaddrc;
  logic sgrpaddrc;
  logic grpmc;
  int_mode_t chintmdc;
  block_tl_t block_tl;
  group_len_t group_len;
  addr_inc_t sinc;
  addr_inc_t dinc;
  tr_width_t src_tr_width;
  tr_width_t dst_tr_width;
  prot_t protctl;
  logic endlan;
  logic srcdtlgc;
  trg_mode_t trgtmdc;
  logic chnen;
  logic sfwtrg;
  logic irq;
  logic pend;

  integer seed;
  row_t rows[$];

  // Reference model state.
  word_t m_sarn;
  word_t m_darn;
  word_t m_ctrl_a;
  word_t m_ctrl_b;
  word_t m_ext;
  logic [4:0] m_mask;
  logic [4:0] m_status;
  logic m_en;

  always #2 hclk = ~hclk;

  dmac_chn_regs u_dut (
    .hclk (hclk), .hrst_n (hrst_n),
    .s_hsel (s_hsel), .s_htrans (s_htrans), .s_haddr (s_haddr),
    .s_hwrite (s_hwrite), .s_hwdata (s_hwdata), .s_hrdata (s_hrdata),
    .err_vld (err_vld), .htfr_vld (htfr_vld), .tfr_vld (tfr_vld),
    .trgetcmp_vld (trgetcmp_vld), .pd_vld (pd_vld), .chnen_clr (chnen_clr),
    .sarn (sarn), .darn (darn), .dgrpaddrc (dgrpaddrc), .sgrpaddrc (sgrpaddrc),
    .grpmc (grpmc), .chintmdc (chintmdc), .block_tl (block_tl), .group_len (group_len),
    .sinc (sinc), .dinc (dinc), .src_tr_width (src_tr_width),
    .dst_tr_width (dst_tr_width), .protctl (protctl), .endlan (endlan),
    .srcdtlgc (srcdtlgc), .trgtmdc (trgtmdc), .chnen (chnen), .sfwtrg (sfwtrg),
    .irq (irq), .pend (pend)
  );

  task automatic fail_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h, expected 0x%h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h, expected 0x%h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_prot(input string name, input prot_t got, input prot_t exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h, expected 0x%h", name, got, exp);
      fail_run();
    end
  endtask

  function automatic word_t next_rand();
    return $random(seed);
  endfunction

  function automatic word_t model_read(input reg_off_t off);
    case (off)
      SARN_OFF:       return m_sarn;
      DARN_OFF:       return m_darn;
      CTRL_A_OFF:     return m_ctrl_a;
      CTRL_B_OFF:     return m_ctrl_b;
      GRPLEN_EXT_OFF: return m_ext;
      INT_MASK_OFF:   return word_t'(m_mask);
      INT_STATUS_OFF: return word_t'(m_status[3:0]);
      CHN_EN_OFF:     return word_t'(m_en);
      default:        return '0;
    endcase
  endfunction

  // Setup registers hold while enabled; unused bits are dropped.
  task automatic model_write(input reg_off_t off, input word_t d);
    if (!m_en) begin
      case (off)
        SARN_OFF:       m_sarn = d;
        DARN_OFF:       m_darn = d;
        CTRL_A_OFF:     m_ctrl_a = d & 32'hB7FF_FFFF;
        CTRL_B_OFF:     m_ctrl_b = d & 32'h0007_E007;
        GRPLEN_EXT_OFF: m_ext = d & 32'h0000_0003;
        default: ;
      endcase
    end
    case (off)
      INT_MASK_OFF:  m_mask = d[4:0];
      INT_CLEAR_OFF: m_status = m_status & ~d[4:0];
      CHN_EN_OFF:    m_en = d[0];
      default: ;
    endcase
  endtask

  task automatic add_row(input row_kind_e kind, input reg_off_t off, input word_t data,
                         input logic [5:0] evt);
    row_t r;
    r.kind = kind;
    r.off = off;
    r.data = data;
    r.evt = evt;
    r.exp = '0;
    case (kind)
      row_wr:   model_write(off, data);
      row_rd:   r.exp = model_read(off);
      row_sreq: r.exp = word_t'(data[0]);
      row_chk: begin
        if (off == GRPLEN_EXT_OFF) begin
          r.exp = word_t'({m_ext[1:0], m_ctrl_a[11:8]});
        end else begin
          r.exp = model_read(off);
        end
      end
      default: ;
    endcase
    // Set wins over a clear in the same cycle.
    m_status = m_status | evt[4:0];
    if (evt[5]) begin
      m_en = 1'b0;
    end
    r.flags = {m_en, m_ctrl_b[0] && |(m_status & m_mask), m_status[4]};
    rows.push_back(r);
  endtask

  task automatic build_table();
    reg_off_t rd_offs [8] = '{SARN_OFF, DARN_OFF, CTRL_A_OFF, CTRL_B_OFF,
                              INT_MASK_OFF, INT_STATUS_OFF, CHN_EN_OFF, GRPLEN_EXT_OFF};
    reg_off_t cfg_offs [5] = '{SARN_OFF, DARN_OFF, CTRL_A_OFF, CTRL_B_OFF, GRPLEN_EXT_OFF};
    foreach (rd_offs[i])
      add_row(row_rd, rd_offs[i], '0, '0);
    // All ones first, then random words.
    for (int pass = 0; pass < 3; pass++) begin
      foreach (cfg_offs[i])
        add_row(row_wr, cfg_offs[i], (pass == 0) ? 32'hFFFF_FFFF : next_rand(), '0);
      foreach (cfg_offs[i]) begin
        add_row(row_rd, cfg_offs[i], '0, '0);
        add_row(row_chk, cfg_offs[i], '0, '0);
      end
    end
    // Enable lock.
    add_row(row_wr, CHN_EN_OFF, 32'h1, '0);
    foreach (cfg_offs[i])
      add_row(row_wr, cfg_offs[i], next_rand(), '0);
    foreach (cfg_offs[i])
      add_row(row_rd, cfg_offs[i], '0, '0);
    add_row(row_wr, INT_MASK_OFF, 32'h1F, '0);
    add_row(row_rd, INT_MASK_OFF, '0, '0);
    add_row(row_rd, CHN_EN_OFF, '0, '0);
    add_row(row_evt, '0, '0, 6'h20);
    add_row(row_wr, SARN_OFF, next_rand(), '0);
    add_row(row_rd, SARN_OFF, '0, '0);
    add_row(row_chk, SARN_OFF, '0, '0);
    // Interrupts.
    add_row(row_wr, CTRL_B_OFF, 32'h1, '0);
    add_row(row_wr, INT_MASK_OFF, 32'h02, '0);
    add_row(row_evt, '0, '0, 6'h01);
    add_row(row_rd, INT_STATUS_OFF, '0, '0);
    add_row(row_evt, '0, '0, 6'h02);
    add_row(row_rd, INT_STATUS_OFF, '0, '0);
    add_row(row_wr, INT_MASK_OFF, 32'h0, '0);
    add_row(row_wr, INT_MASK_OFF, 32'h1F, '0);
    add_row(row_wr, CTRL_B_OFF, 32'h0, '0);
    add_row(row_wr, CTRL_B_OFF, 32'h1, '0);
    add_row(row_wr, INT_CLEAR_OFF, 32'h01, '0);
    add_row(row_rd, INT_STATUS_OFF, '0, '0);
    add_row(row_wr, INT_CLEAR_OFF, 32'h02, 6'h02);
    add_row(row_rd, INT_STATUS_OFF, '0, '0);
    add_row(row_evt, '0, '0, 6'h10);
    add_row(row_rd, INT_STATUS_OFF, '0, '0);
    add_row(row_wr, INT_CLEAR_OFF, 32'h10, '0);
    add_row(row_evt, '0, '0, 6'h0C);
    add_row(row_rd, INT_STATUS_OFF, '0, '0);
    add_row(row_wr, INT_CLEAR_OFF, 32'h1F, '0);
    // Software request.
    add_row(row_sreq, SOFT_REQ_OFF, 32'h1, '0);
    add_row(row_sreq, SOFT_REQ_OFF, 32'h0, '0);
    add_row(row_sreq, SOFT_REQ_OFF, 32'hFFFF_FFFE, '0);
    // Unmapped, write-only, deselected and idle accesses.
    add_row(row_rd, reg_off_t'(CHN_BASE_OFF + 10'h028), '0, '0);
    add_row(row_rd, 10'h000, '0, '0);
    add_row(row_rd, 10'h3FC, '0, '0);
    add_row(row_rd, INT_CLEAR_OFF, '0, '0);
    add_row(row_rd, SOFT_REQ_OFF, '0, '0);
    add_row(row_rd_nosel, SARN_OFF, '0, '0);
    add_row(row_rd_idle, SARN_OFF, '0, '0);
    add_row(row_wr, reg_off_t'(CHN_BASE_OFF + 10'h028), next_rand(), '0);
    add_row(row_wr, INT_STATUS_OFF, 32'h1F, '0);
    add_row(row_wr_nosel, SARN_OFF, next_rand(), '0);
    add_row(row_wr_idle, CTRL_A_OFF, next_rand(), '0);
    add_row(row_wr_nosel, CHN_EN_OFF, 32'h1, '0);
    add_row(row_wr_idle, INT_MASK_OFF, 32'h0, '0);
    foreach (rd_offs[i])
      add_row(row_rd, rd_offs[i], '0, '0);
  endtask

  task automatic drive_events(input logic [5:0] evt);
    pd_vld       = evt[4];
    trgetcmp_vld = evt[3];
    htfr_vld     = evt[2];
    tfr_vld      = evt[1];
    err_vld      = evt[0];
    chnen_clr    = evt[5];
  endtask

  task automatic check_fields(input reg_off_t off, input word_t exp);
    case (off)
      SARN_OFF: check_word("sarn", sarn, exp);
      DARN_OFF: check_word("darn", darn, exp);
      GRPLEN_EXT_OFF: check_word("group_len", word_t'(group_len), exp);
      CTRL_A_OFF: begin
        check_bit("dgrpaddrc", dgrpaddrc, exp[31]);
        check_bit("sgrpaddrc", sgrpaddrc, exp[29]);
        check_bit("grpmc", grpmc, exp[28]);
        check_word("chintmdc", word_t'(chintmdc), word_t'(exp[26:24]));
        check_word("block_tl", word_t'(block_tl), word_t'(exp[23:12]));
        check_word("sinc", word_t'(sinc), word_t'(exp[7:6]));
        check_word("dinc", word_t'(dinc), word_t'(exp[5:4]));
        check_word("src_tr_width", word_t'(src_tr_width), word_t'(exp[3:2]));
        check_word("dst_tr_width", word_t'(dst_tr_width), word_t'(exp[1:0]));
      end
      CTRL_B_OFF: begin
        check_prot("protctl", protctl, exp[18:15]);
        check_bit("endlan", endlan, exp[14]);
        check_bit("srcdtlgc", srcdtlgc, exp[13]);
        check_word("trgtmdc", word_t'(trgtmdc), word_t'(exp[2:1]));
      end
      default: ;
    endcase
  endtask

  task automatic wait_sfwtrg(input logic expect_pulse);
    int cycles;
    logic seen;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < SFW_TIMEOUT) begin
      @(posedge hclk);
      #1;
      seen = sfwtrg;
      cycles++;
    end
    if (expect_pulse && !seen) begin
      $display("Timed out after %0d cycles waiting for the sfwtrg pulse", SFW_TIMEOUT);
      fail_run();
    end else begin
      check_bit("sfwtrg", seen, expect_pulse);
      if (seen) begin
        @(posedge hclk);
        #1;
        check_bit("sfwtrg", sfwtrg, 1'b0);
      end
    end
  endtask

  // Address phase, data phase, then one idle cycle carrying the events.
  task automatic apply_row(input row_t r);
    logic is_wr;
    logic is_rd;
    is_wr = (r.kind == row_wr || r.kind == row_wr_nosel || r.kind == row_wr_idle ||
             r.kind == row_sreq);
    is_rd = (r.kind == row_rd || r.kind == row_rd_nosel || r.kind == row_rd_idle);
    @(posedge hclk);
    #1;
    if (is_wr || is_rd) begin
      s_hsel   = (r.kind != row_wr_nosel && r.kind != row_rd_nosel);
      s_htrans = (r.kind == row_wr_idle || r.kind == row_rd_idle) ? HTRANS_IDLE
                                                                  : HTRANS_NONSEQ;
      s_haddr  = ADDR_HI | word_t'(r.off);
      s_hwrite = is_wr;
    end
    @(posedge hclk);
    #1;
    s_hsel   = 1'b0;
    s_htrans = HTRANS_IDLE;
    s_hwrite = 1'b0;
    s_hwdata = r.data;
    #1;
    if (is_rd) begin
      check_word("s_hrdata", s_hrdata, r.exp);
    end
    if (r.kind == row_chk) begin
      check_fields(r.off, r.exp);
    end
    if (r.kind == row_sreq) begin
      wait_sfwtrg(r.exp[0]);
    end else begin
      @(posedge hclk);
      #1;
      s_hwdata = '0;
      drive_events(r.evt);
      @(posedge hclk);
      #1;
      drive_events('0);
      check_bit("sfwtrg", sfwtrg, 1'b0);
    end
    #1;
    check_bit("chnen", chnen, r.flags[2]);
    check_bit("irq", irq, r.flags[1]);
    check_bit("pend", pend, r.flags[0]);
  endtask

  initial begin
    hrst_n   = 1'b0;
    s_hsel   = 1'b0;
    s_htrans = HTRANS_IDLE;
    s_haddr  = '0;
    s_hwrite = 1'b0;
    s_hwdata = '0;
    drive_events('0);
    seed     = 32'hc8a9;
    m_sarn   = '0;
    m_darn   = '0;
    m_ctrl_a = '0;
    m_ctrl_b = '0;
    m_ext    = '0;
    m_mask   = '0;
    m_status = '0;
    m_en     = 1'b0;
    build_table();
    repeat (4) @(posedge hclk);
    #1;
    hrst_n = 1'b1;
    check_bit("chnen", chnen, 1'b0);
    check_bit("irq", irq, 1'b0);
    check_bit("pend", pend, 1'b0);
    check_bit("sfwtrg", sfwtrg, 1'b0);
    foreach (rows[i])
      apply_row(rows[i]);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: dmac_chn_properties.sv
`timescale 1ns/1ns
`default_nettype none

module dmac_chn_properties
  import dmac_chn_pkg::*;
(
  input  wire logic hclk,
  input  wire logic hrst_n,
  input  reg_sel_e  wr_sel,
  input  reg_sel_e  rd_sel,
  input  word_t     s_hrdata,
  input  wire logic sfwtrg
);

  // Software request is a single-cycle pulse.
  a_sfwtrg_single : assert property (
    @(posedge hclk) disable iff (!hrst_n) sfwtrg |=> !sfwtrg
  ) else $error("sfwtrg high for two cycles in a row");

  a_sel_exclusive : assert property (
    @(posedge hclk) disable iff (!hrst_n) !(rd_sel != sel_none && wr_sel != sel_none)
  ) else $error("read and write selects active together");

  // Bus is quiet outside a read data phase.
  a_rdata_idle : assert property (
    @(posedge hclk) disable iff (!hrst_n) (rd_sel == sel_none) |-> (s_hrdata == '0)
  ) else $error("s_hrdata not zero without a read select");

endmodule

bind ahb_reg_slave dmac_chn_properties u_slave_props (
  .hclk     (hclk),
  .hrst_n   (hrst_n),
  .wr_sel   (wr_sel),
  .rd_sel   (rd_sel),
  .s_hrdata (s_hrdata),
  .sfwtrg   (1'b0)
);

bind chn_ctrl_regs dmac_chn_properties u_ctrl_props (
  .hclk     (hclk),
  .hrst_n   (hrst_n),
  .wr_sel   (wr_sel),
  .rd_sel   (rd_sel),
  .s_hrdata (rd_word),
  .sfwtrg   (sfwtrg)
);

`default_nettype wire

// File: dmac_chn_regs.sv
`timescale 1ns/1ns
`default_nettype none

module dmac_chn_regs
  import dmac_chn_pkg::*;
(
  input  wire logic       hclk,
  input  wire logic       hrst_n,
  input  wire logic       s_hsel,
  input  wire logic [1:0] s_htrans,
  input  word_t           s_haddr,
  input  wire logic       s_hwrite,
  input  word_t           s_hwdata,
  output word_t           s_hrdata,
  input  wire logic       err_vld,
  input  wire logic       htfr_vld,
  input  wire logic       tfr_vld,
  input  wire logic       trgetcmp_vld,
  input  wire logic       pd_vld,
  input  wire logic       chnen_clr,
  output word_t           sarn,
  output word_t           darn,
  output logic            dgrpaddrc,
  output logic            sgrpaddrc,
  output logic            grpmc,
  output int_mode_t       chintmdc,
  output block_tl_t       block_tl,
  output group_len_t      group_len,
  output addr_inc_t       sinc,
  output addr_inc_t       dinc,
  output tr_width_t       src_tr_width,
  output tr_width_t       dst_tr_width,
  output prot_t           protctl,
  output logic            endlan,
  output logic            srcdtlgc,
  output trg_mode_t       trgtmdc,
  output logic            chnen,
  output logic            sfwtrg,
  output logic            irq,
  output logic            pend
);

  reg_sel_e wr_sel;
  reg_sel_e rd_sel;
  word_t    cfg_rd_word;
  word_t    int_rd_word;
  word_t    ctrl_rd_word;
  logic     int_en;
  int_vec_t evt;

  // Event vector from the FSM strobes.
  always_comb begin
    evt = '0;
    evt[INT_PEND_BIT]   = pd_vld;
    evt[INT_TRGCMP_BIT] = trgetcmp_vld;
    evt[INT_HTFR_BIT]   = htfr_vld;
    evt[INT_TFR_BIT]    = tfr_vld;
    evt[INT_ERR_BIT]    = err_vld;
  end

  ahb_reg_slave u_slave (
    .hclk         (hclk),
    .hrst_n       (hrst_n),
    .s_hsel       (s_hsel),
    .s_htrans     (s_htrans),
    .s_haddr      (s_haddr),
    .s_hwrite     (s_hwrite),
    .cfg_rd_word  (cfg_rd_word),
    .int_rd_word  (int_rd_word),
    .ctrl_rd_word (ctrl_rd_word),
    .wr_sel       (wr_sel),
    .rd_sel       (rd_sel),
    .s_hrdata     (s_hrdata)
  );

  chn_cfg_regs u_cfg (
    .hclk         (hclk),
    .hrst_n       (hrst_n),
    .wr_sel       (wr_sel),
    .rd_sel       (rd_sel),
    .s_hwdata     (s_hwdata),
    .chn_en       (chnen),
    .sarn         (sarn),
    .darn         (darn),
    .dgrpaddrc    (dgrpaddrc),
    .sgrpaddrc    (sgrpaddrc),
    .grpmc        (grpmc),
    .chintmdc     (chintmdc),
    .block_tl     (block_tl),
    .group_len    (group_len),
    .sinc         (sinc),
    .dinc         (dinc),
    .src_tr_width (src_tr_width),
    .dst_tr_width (dst_tr_width),
    .protctl      (protctl),
    .endlan       (endlan),
    .srcdtlgc     (srcdtlgc),
    .trgtmdc      (trgtmdc),
    .int_en       (int_en),
    .rd_word      (cfg_rd_word)
  );

  chn_int_regs u_int (
    .hclk     (hclk),
    .hrst_n   (hrst_n),
    .wr_sel   (wr_sel),
    .rd_sel   (rd_sel),
    .s_hwdata (s_hwdata),
    .int_en   (int_en),
    .evt      (evt),
    .irq      (irq),
    .pend     (pend),
    .rd_word  (int_rd_word)
  );

  chn_ctrl_regs u_ctrl (
    .hclk      (hclk),
    .hrst_n    (hrst_n),
    .wr_sel    (wr_sel),
    .rd_sel    (rd_sel),
    .s_hwdata  (s_hwdata),
    .chnen_clr (chnen_clr),
    .chn_en    (chnen),
    .sfwtrg    (sfwtrg),
    .rd_word   (ctrl_rd_word)
  );

endmodule

`default_nettype wire

// File: chn_ctrl_regs.sv
`timescale 1ns/1ns
`default_nettype none

module chn_ctrl_regs
  import dmac_chn_pkg::*;
(
  input  wire logic hclk,
  input  wire logic hrst_n,
  input  reg_sel_e  wr_sel,
  input  reg_sel_e  rd_sel,
  input  word_t     s_hwdata,
  input  wire logic chnen_clr,
  output logic      chn_en,
  output logic      sfwtrg,
  output word_t     rd_word
);

  // Bus write wins over the FSM clear.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      chn_en <= 1'b0;
    end else if (wr_sel == sel_chn_en) begin
      chn_en <= s_hwdata[0];
    end else if (chnen_clr) begin
      chn_en <= 1'b0;
    end
  end

  // Request lasts one cycle per write.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      sfwtrg <= 1'b0;
    end else begin
      sfwtrg <= (wr_sel == sel_soft_req) && s_hwdata[0];
    end
  end

  assign rd_word = (rd_sel == sel_chn_en) ? word_t'(chn_en) : '0;

endmodule

`default_nettype wire

// File: chn_int_regs.sv
`timescale 1ns/1ns
`default_nettype none

module chn_int_regs
  import dmac_chn_pkg::*;
(
  input  wire logic hclk,
  input  wire logic hrst_n,
  input  reg_sel_e  wr_sel,
  input  reg_sel_e  rd_sel,
  input  word_t     s_hwdata,
  input  wire logic int_en,
  input  int_vec_t  evt,
  output logic      irq,
  output logic      pend,
  output word_t     rd_word
);

  int_vec_t mask;
  int_vec_t status;
  int_vec_t clr;
  int_vec_t status_vis;

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      mask <= '0;
    end else if (wr_sel == sel_int_mask) begin
      mask <= s_hwdata[$bits(int_vec_t)-1:0];
    end
  end

  // One-cycle clear pulses from the write-one-to-clear register.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      clr <= '0;
    end else if (wr_sel == sel_int_clear) begin
      clr <= s_hwdata[$bits(int_vec_t)-1:0];
    end else begin
      clr <= '0;
    end
  end

  // Sticky status. An event beats a clear in the same cycle.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      status <= '0;
    end else begin
      status <= evt | (status & ~clr);
    end
  end

  assign irq  = int_en && |(status & mask);
  assign pend = status[INT_PEND_BIT];

  // Pending is not part of the status read-back.
  always_comb begin
    status_vis = status;
    status_vis[INT_PEND_BIT] = 1'b0;
  end

  always_comb begin
    case (rd_sel)
      sel_int_mask:   rd_word = word_t'(mask);
      sel_int_status: rd_word = word_t'(status_vis);
      default:        rd_word = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: chn_cfg_regs.sv
`timescale 1ns/1ns
`default_nettype none

module chn_cfg_regs
  import dmac_chn_pkg::*;
(
  input  wire logic hclk,
  input  wire logic hrst_n,
  input  reg_sel_e  wr_sel,
  input  reg_sel_e  rd_sel,
  input  word_t     s_hwdata,
  input  wire logic chn_en,
  output word_t     sarn,
  output word_t     darn,
  output logic      dgrpaddrc,
  output logic      sgrpaddrc,
  output logic      grpmc,
  output int_mode_t chintmdc,
  output block_tl_t block_tl,
  output group_len_t group_len,
  output addr_inc_t sinc,
  output addr_inc_t dinc,
  output tr_width_t src_tr_width,
  output tr_width_t dst_tr_width,
  output prot_t     protctl,
  output logic      endlan,
  output logic      srcdtlgc,
  output trg_mode_t trgtmdc,
  output logic      int_en,
  output word_t     rd_word
);

  word_t ctrl_a_word;
  word_t ctrl_b_word;
  word_t grplen_ext_word;

  // Setup is frozen while the channel runs.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      sarn         <= '0;
      darn         <= '0;
      dgrpaddrc    <= 1'b0;
      sgrpaddrc    <= 1'b0;
      grpmc        <= 1'b0;
      chintmdc     <= '0;
      block_tl     <= '0;
      group_len    <= '0;
      sinc         <= '0;
      dinc         <= '0;
      src_tr_width <= '0;
      dst_tr_width <= '0;
      protctl      <= '0;
      endlan       <= 1'b0;
      srcdtlgc     <= 1'b0;
      trgtmdc      <= '0;
      int_en       <= 1'b0;
    end else if (!chn_en) begin
      case (wr_sel)
        sel_sarn: sarn <= s_hwdata;
        sel_darn: darn <= s_hwdata;
        sel_ctrl_a: begin
          dgrpaddrc    <= s_hwdata[CTRLA_DGRPADDRC_BIT];
          sgrpaddrc    <= s_hwdata[CTRLA_SGRPADDRC_BIT];
          grpmc        <= s_hwdata[CTRLA_GRPMC_BIT];
          chintmdc     <= s_hwdata[CTRLA_CHINTMDC_LSB +: $bits(int_mode_t)];
          block_tl     <= s_hwdata[CTRLA_BLOCK_TL_LSB +: $bits(block_tl_t)];
          group_len[GRPLEN_A_W-1:0] <= s_hwdata[CTRLA_GROUP_LEN_LSB +: GRPLEN_A_W];
          sinc         <= s_hwdata[CTRLA_SINC_LSB +: $bits(addr_inc_t)];
          dinc         <= s_hwdata[CTRLA_DINC_LSB +: $bits(addr_inc_t)];
          src_tr_width <= s_hwdata[CTRLA_SRC_WIDTH_LSB +: $bits(tr_width_t)];
          dst_tr_width <= s_hwdata[CTRLA_DST_WIDTH_LSB +: $bits(tr_width_t)];
        end
        sel_grplen_ext: begin
          group_len[GRPLEN_A_W +: GRPLEN_EXT_W] <= s_hwdata[GRPLEN_EXT_W-1:0];
        end
        sel_ctrl_b: begin
          protctl  <= s_hwdata[CTRLB_PROTCTL_LSB +: $bits(prot_t)];
          endlan   <= s_hwdata[CTRLB_ENDLAN_BIT];
          srcdtlgc <= s_hwdata[CTRLB_SRCDTLGC_BIT];
          trgtmdc  <= s_hwdata[CTRLB_TRGTMDC_LSB +: $bits(trg_mode_t)];
          int_en   <= s_hwdata[CTRLB_INT_EN_BIT];
        end
        default: ;
      endcase
    end
  end

  // Read-back words with unused bits zero.
  always_comb begin
    ctrl_a_word = '0;
    ctrl_a_word[CTRLA_DGRPADDRC_BIT] = dgrpaddrc;
    ctrl_a_word[CTRLA_SGRPADDRC_BIT] = sgrpaddrc;
    ctrl_a_word[CTRLA_GRPMC_BIT]     = grpmc;
    ctrl_a_word[CTRLA_CHINTMDC_LSB +: $bits(int_mode_t)]  = chintmdc;
    ctrl_a_word[CTRLA_BLOCK_TL_LSB +: $bits(block_tl_t)]  = block_tl;
    ctrl_a_word[CTRLA_GROUP_LEN_LSB +: GRPLEN_A_W]        = group_len[GRPLEN_A_W-1:0];
    ctrl_a_word[CTRLA_SINC_LSB +: $bits(addr_inc_t)]      = sinc;
    ctrl_a_word[CTRLA_DINC_LSB +: $bits(addr_inc_t)]      = dinc;
    ctrl_a_word[CTRLA_SRC_WIDTH_LSB +: $bits(tr_width_t)] = src_tr_width;
    ctrl_a_word[CTRLA_DST_WIDTH_LSB +: $bits(tr_width_t)] = dst_tr_width;

    ctrl_b_word = '0;
    ctrl_b_word[CTRLB_PROTCTL_LSB +: $bits(prot_t)]     = protctl;
    ctrl_b_word[CTRLB_ENDLAN_BIT]                       = endlan;
    ctrl_b_word[CTRLB_SRCDTLGC_BIT]                     = srcdtlgc;
    ctrl_b_word[CTRLB_TRGTMDC_LSB +: $bits(trg_mode_t)] = trgtmdc;
    ctrl_b_word[CTRLB_INT_EN_BIT]                       = int_en;

    grplen_ext_word = '0;
    grplen_ext_word[GRPLEN_EXT_W-1:0] = group_len[GRPLEN_A_W +: GRPLEN_EXT_W];
  end

  always_comb begin
    case (rd_sel)
      sel_sarn:       rd_word = sarn;
      sel_darn:       rd_word = darn;
      sel_ctrl_a:     rd_word = ctrl_a_word;
      sel_ctrl_b:     rd_word = ctrl_b_word;
      sel_grplen_ext: rd_word = grplen_ext_word;
      default:        rd_word = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: ahb_reg_slave.sv
`timescale 1ns/1ns
`default_nettype none

module ahb_reg_slave
  import dmac_chn_pkg::*;
(
  input  wire logic       hclk,
  input  wire logic       hrst_n,
  input  wire logic       s_hsel,
  input  wire logic [1:0] s_htrans,
  input  word_t           s_haddr,
  input  wire logic       s_hwrite,
  input  word_t           cfg_rd_word,
  input  word_t           int_rd_word,
  input  word_t           ctrl_rd_word,
  output reg_sel_e        wr_sel,
  output reg_sel_e        rd_sel,
  output word_t           s_hrdata
);

  logic     access;
  logic     readable;
  logic     writable;
  reg_sel_e addr_sel;

  function automatic reg_sel_e decode_off(input reg_off_t off);
    reg_sel_e sel;
    case (off)
      SARN_OFF:       sel = sel_sarn;
      DARN_OFF:       sel = sel_darn;
      CTRL_A_OFF:     sel = sel_ctrl_a;
      CTRL_B_OFF:     sel = sel_ctrl_b;
      INT_MASK_OFF:   sel = sel_int_mask;
      INT_STATUS_OFF: sel = sel_int_status;
      INT_CLEAR_OFF:  sel = sel_int_clear;
      SOFT_REQ_OFF:   sel = sel_soft_req;
      CHN_EN_OFF:     sel = sel_chn_en;
      GRPLEN_EXT_OFF: sel = sel_grplen_ext;
      default:        sel = sel_none;
    endcase
    return sel;
  endfunction

  // Only NONSEQ and SEQ transfers to this slave count.
  assign access = s_hsel && (s_htrans == HTRANS_NONSEQ || s_htrans == HTRANS_SEQ);

  assign addr_sel = decode_off(s_haddr[$bits(reg_off_t)-1:0]);

  // Clear and soft request are write-only.
  assign readable = (addr_sel != sel_int_clear) && (addr_sel != sel_soft_req);

  // Status is read-only.
  assign writable = (addr_sel != sel_int_status);

  // Selects hold for the data phase.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      wr_sel <= sel_none;
      rd_sel <= sel_none;
    end else begin
      wr_sel <= (access && s_hwrite && writable) ? addr_sel : sel_none;
      rd_sel <= (access && !s_hwrite && readable) ? addr_sel : sel_none;
    end
  end

  // Banks return zero unless selected.
  assign s_hrdata = cfg_rd_word | int_rd_word | ctrl_rd_word;

endmodule

`default_nettype wire

// File: dmac_chn_pkg.sv
`default_nettype none

package dmac_chn_pkg;

  typedef logic [31:0] word_t;
  typedef logic [9:0]  reg_off_t;
  typedef logic [11:0] block_tl_t;
  typedef logic [5:0]  group_len_t;
  typedef logic [1:0]  tr_width_t;
  typedef logic [1:0]  addr_inc_t;
  typedef logic [2:0]  int_mode_t;
  typedef logic [1:0]  trg_mode_t;
  typedef logic [3:0]  prot_t;
  typedef logic [4:0]  int_vec_t;

  typedef enum logic [3:0] {
    sel_none,
    sel_sarn,
    sel_darn,
    sel_ctrl_a,
    sel_ctrl_b,
    sel_int_mask,
    sel_int_status,
    sel_int_clear,
    sel_soft_req,
    sel_chn_en,
    sel_grplen_ext
  } reg_sel_e;

  localparam reg_off_t CHN_BASE_OFF   = 10'h0F0;
  localparam reg_off_t SARN_OFF       = CHN_BASE_OFF + 10'h000;
  localparam reg_off_t DARN_OFF       = CHN_BASE_OFF + 10'h004;
  localparam reg_off_t CTRL_A_OFF     = CHN_BASE_OFF + 10'h008;
  localparam reg_off_t CTRL_B_OFF     = CHN_BASE_OFF + 10'h00C;
  localparam reg_off_t INT_MASK_OFF   = CHN_BASE_OFF + 10'h010;
  localparam reg_off_t INT_STATUS_OFF = CHN_BASE_OFF + 10'h014;
  localparam reg_off_t INT_CLEAR_OFF  = CHN_BASE_OFF + 10'h018;
  localparam reg_off_t SOFT_REQ_OFF   = CHN_BASE_OFF + 10'h01C;
  localparam reg_off_t CHN_EN_OFF     = CHN_BASE_OFF + 10'h020;
  localparam reg_off_t GRPLEN_EXT_OFF = CHN_BASE_OFF + 10'h024;

  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // Control A fields.
  localparam int CTRLA_DGRPADDRC_BIT = 31;
  localparam int CTRLA_SGRPADDRC_BIT = 29;
  localparam int CTRLA_GRPMC_BIT     = 28;
  localparam int CTRLA_CHINTMDC_LSB  = 24;
  localparam int CTRLA_BLOCK_TL_LSB  = 12;
  localparam int CTRLA_GROUP_LEN_LSB = 8;
  localparam int CTRLA_SINC_LSB      = 6;
  localparam int CTRLA_DINC_LSB      = 4;
  localparam int CTRLA_SRC_WIDTH_LSB = 2;
  localparam int CTRLA_DST_WIDTH_LSB = 0;

  // Group length split between control A and the extension.
  localparam int GRPLEN_A_W   = 4;
  localparam int GRPLEN_EXT_W = 2;

  // Control B fields.
  localparam int CTRLB_PROTCTL_LSB   = 15;
  localparam int CTRLB_ENDLAN_BIT    = 14;
  localparam int CTRLB_SRCDTLGC_BIT  = 13;
  localparam int CTRLB_TRGTMDC_LSB   = 1;
  localparam int CTRLB_INT_EN_BIT    = 0;

  // Interrupt vector bits.
  localparam int INT_PEND_BIT   = 4;
  localparam int INT_TRGCMP_BIT = 3;
  localparam int INT_HTFR_BIT   = 2;
  localparam int INT_TFR_BIT    = 1;
  localparam int INT_ERR_BIT    = 0;

endpackage

`default_nettype wire
